// File: src/adpcma_pkg.sv
// shared widths, register map, slot timing constants and channel state enum
`default_nettype none

package adpcma_pkg;

    typedef logic [23:0]        rom_addr_t;     // byte address into sample rom
    typedef logic [15:0]        block_t;        // 256-byte block number
    typedef logic [3:0]         nibble_t;       // one adpcm code
    typedef logic signed [15:0] pcm_t;          // audio sample
    typedef logic [2:0]         ch_idx_t;       // channel number
    typedef logic [5:0]         atten_t;        // attenuation, 8 fine steps per octave
    typedef logic [5:0]         reg_addr_t;

    // register map
    localparam reg_addr_t reg_key      = 6'h00; // bit 7 dump, 5:0 channel mask
    localparam reg_addr_t reg_total    = 6'h01; // total attenuation
    localparam reg_addr_t reg_flag_clr = 6'h02; // end flag clear mask
    localparam reg_addr_t reg_pan_base = 6'h08; // +ch, 7:6 l/r enable, 4:0 ch attenuation
    localparam reg_addr_t reg_start_lo = 6'h10; // +ch
    localparam reg_addr_t reg_start_hi = 6'h18;
    localparam reg_addr_t reg_end_lo   = 6'h20;
    localparam reg_addr_t reg_end_hi   = 6'h28;

    // clocks per channel slot
    localparam int slot_cycles = 4;

    // top of the adaptive step table
    localparam int step_max = 48;

    // per-channel playback state
    typedef enum logic [1:0] {
        idle,       // no fetch, zero sample
        play_hi,    // fetch byte, play high nibble
        play_lo     // play low nibble of latched byte
    } chan_state_e;

endpackage

`default_nettype wire

// File: src/adpcma_seq.sv
// register file, slot counter, channel address counters, rom fetch and end flags
`default_nettype none

module adpcma_seq #(
    parameter int num_ch = 6
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wr,
    input  wire adpcma_pkg::reg_addr_t wr_addr,
    input  wire [7:0]                  wr_data,
    input  wire [7:0]                  rom_data,
    input  wire adpcma_pkg::ch_idx_t   pan_ch,
    output adpcma_pkg::rom_addr_t      rom_addr,
    output logic                       rom_oe_n,
    output logic [num_ch-1:0]          flags,
    output logic                       nib_valid,
    output adpcma_pkg::ch_idx_t        nib_ch,
    output adpcma_pkg::nibble_t        nib,
    output logic                       nib_restart,
    output logic [1:0]                 pan_lr,
    output adpcma_pkg::atten_t         pan_atten
);
    import adpcma_pkg::*;

    localparam int cyc_w = $clog2(slot_cycles);

    logic [cyc_w-1:0]  slot_cyc;
    ch_idx_t           slot_ch, nxt_ch;
    logic              slot_end, slot_fetch;
    atten_t            total_att;
    logic [1:0]        pan_r     [num_ch];
    logic [4:0]        ch_att    [num_ch];
    block_t            start_blk [num_ch];
    block_t            end_blk   [num_ch];
    chan_state_e       state     [num_ch];
    rom_addr_t         addr      [num_ch];
    logic [7:0]        byte_q    [num_ch];  // byte held for the low nibble
    logic [num_ch-1:0] fresh, key_pend, dump_pend;
    logic [num_ch-1:0] key_wr, dump_wr, clr_wr, key_now, dump_now, take, end_set;
    chan_state_e       eff_state;
    rom_addr_t         eff_addr;
    ch_idx_t           wr_ch;
    logic              wr_ch_ok;
    logic [6:0]        att_sum;

    assign slot_end   = (slot_cyc == cyc_w'(slot_cycles - 1));
    assign slot_fetch = (slot_cyc == cyc_w'(1));    // rom_data valid here
    assign nxt_ch     = (slot_ch == ch_idx_t'(num_ch - 1)) ? '0 : slot_ch + 3'd1;
    assign wr_ch      = ch_idx_t'(wr_addr[2:0]);
    assign wr_ch_ok   = int'(wr_addr[2:0]) < num_ch;

    // key-on / dump / flag clear masks, pending commands resolved at slot start
    always_comb begin
        key_wr  = '0;
        dump_wr = '0;
        clr_wr  = '0;
        take    = '0;
        end_set = '0;
        if (wr && wr_addr == reg_key) begin
            if (wr_data[7]) begin
                dump_wr = wr_data[num_ch-1:0];
            end else begin
                key_wr = wr_data[num_ch-1:0];
            end
        end
        if (wr && wr_addr == reg_flag_clr) begin
            clr_wr = wr_data[num_ch-1:0];
        end
        key_now  = key_pend | key_wr;
        dump_now = dump_pend | dump_wr;
        if (slot_end) begin
            take[nxt_ch] = 1'b1;
        end
        if (dump_now[nxt_ch]) begin
            eff_state = idle;   // dump wins over key-on
        end else if (key_now[nxt_ch]) begin
            eff_state = play_hi;
        end else begin
            eff_state = state[nxt_ch];
        end
        eff_addr = key_now[nxt_ch] ? {start_blk[nxt_ch], 8'h00} : addr[nxt_ch];
        // last byte of end block, low nibble going out now
        if (slot_fetch && state[slot_ch] == play_lo && addr[slot_ch] == {end_blk[slot_ch], 8'hff}) begin
            end_set[slot_ch] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_cyc    <= '0;
            slot_ch     <= '0;
            total_att   <= '0;
            rom_addr    <= '0;
            rom_oe_n    <= 1'b1;
            flags       <= '0;
            fresh       <= '0;
            key_pend    <= '0;
            dump_pend   <= '0;
            nib_valid   <= 1'b0;
            nib_restart <= 1'b0;
            for (int i = 0; i < num_ch; i++) begin
                pan_r[i]     <= '0;
                ch_att[i]    <= '0;
                start_blk[i] <= '0;
                end_blk[i]   <= '0;
                state[i]     <= idle;
                addr[i]      <= '0;
            end
        end else begin
            slot_cyc  <= slot_end ? '0 : slot_cyc + 1'b1;
            key_pend  <= (key_pend | key_wr) & ~take;
            dump_pend <= (dump_pend | dump_wr) & ~take;
            flags     <= (flags & ~clr_wr) | end_set;     // a new end beats the clear
            if (wr && wr_addr == reg_total) begin
                total_att <= wr_data[5:0];
            end
            if (wr && wr_ch_ok) begin
                case (wr_addr[5:3])
                    reg_pan_base[5:3]: begin
                        pan_r[wr_ch]  <= wr_data[7:6];
                        ch_att[wr_ch] <= wr_data[4:0];
                    end
                    reg_start_lo[5:3]: start_blk[wr_ch][7:0]  <= wr_data;
                    reg_start_hi[5:3]: start_blk[wr_ch][15:8] <= wr_data;
                    reg_end_lo[5:3]:   end_blk[wr_ch][7:0]    <= wr_data;
                    reg_end_hi[5:3]:   end_blk[wr_ch][15:8]   <= wr_data;
                    default: ;
                endcase
            end
            nib_valid   <= 1'b0;
            nib_restart <= 1'b0;
            if (slot_end) begin     // set up cycle 0 of the next slot
                slot_ch       <= nxt_ch;
                state[nxt_ch] <= eff_state;
                addr[nxt_ch]  <= eff_addr;
                fresh[nxt_ch] <= fresh[nxt_ch] | key_now[nxt_ch];
                rom_addr      <= eff_addr;
                rom_oe_n      <= (eff_state != play_hi);   // low through cycle 1
            end
            if (slot_fetch) begin
                rom_oe_n       <= 1'b1;
                nib_valid      <= (state[slot_ch] != idle);
                nib_restart    <= fresh[slot_ch] | (state[slot_ch] == idle);  // idle clears decoder
                fresh[slot_ch] <= 1'b0;
                case (state[slot_ch])
                    play_hi: state[slot_ch] <= play_lo;
                    play_lo: begin
                        if (end_set[slot_ch]) begin
                            state[slot_ch] <= idle;
                        end else begin
                            state[slot_ch] <= play_hi;
                            addr[slot_ch]  <= addr[slot_ch] + 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // nibble payload and fetched byte
    always_ff @(posedge clk) begin
        if (slot_fetch) begin
            nib_ch <= slot_ch;
            case (state[slot_ch])
                play_hi: begin
                    nib             <= rom_data[7:4];   // high nibble first
                    byte_q[slot_ch] <= rom_data;
                end
                play_lo: nib <= byte_q[slot_ch][3:0];
                default: nib <= '0;
            endcase
        end
    end

    // pan and attenuation for the channel now in the level stage
    assign pan_lr    = pan_r[pan_ch];
    assign att_sum   = {1'b0, total_att} + {2'b00, ch_att[pan_ch]};
    assign pan_atten = att_sum[6] ? 6'h3f : att_sum[5:0];   // clip at 63

    a_oe_playing: assert property (@(posedge clk) disable iff (!rst_n)
        !rom_oe_n |-> (state[slot_ch] == play_hi) && (slot_cyc < cyc_w'(2)))
        else $error("rom read in a slot whose channel is not fetching");

endmodule

`default_nettype wire

// File: src/adpcma_decode.sv
// per-channel adpcm-a nibble decoder with step index and accumulator memory
`default_nettype none

module adpcma_decode #(
    parameter int num_ch = 6
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      nib_valid,
    input  wire adpcma_pkg::ch_idx_t nib_ch,
    input  wire adpcma_pkg::nibble_t nib,
    input  wire                      nib_restart,
    output logic                     dec_valid,
    output adpcma_pkg::ch_idx_t      dec_ch,
    output adpcma_pkg::pcm_t         dec_pcm
);
    import adpcma_pkg::*;

    // adpcm-a step sizes, index 0..step_max
    localparam logic [10:0] step_tab [0:step_max] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37,
        41, 45, 50, 55, 60, 66, 73, 80, 88, 97,
        107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
        279, 307, 337, 371, 408, 449, 494, 544, 598, 658,
        724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552
    };

    logic signed [11:0] acc_mem  [num_ch];
    logic [5:0]         step_mem [num_ch];
    logic signed [11:0] base_acc, new_acc;
    logic [5:0]         base_step, new_step;
    logic [14:0]        prod;
    logic [11:0]        delta;
    logic signed [13:0] sum;
    logic signed [7:0]  adj, idx_sum;

    always_comb begin
        base_acc  = nib_restart ? 12'sd0 : acc_mem[nib_ch];    // restart zeroes first
        base_step = nib_restart ? 6'd0 : step_mem[nib_ch];
        prod      = 15'({nib[2:0], 1'b1}) * 15'(step_tab[base_step]);  // (2m+1)*step
        delta     = prod[14:3];
        sum       = base_acc;
        if (nib[3]) begin
            sum = sum - $signed({2'b00, delta});
        end else begin
            sum = sum + $signed({2'b00, delta});
        end
        if (sum > 14'sd2047) begin
            new_acc = 12'sd2047;
        end else if (sum < -14'sd2048) begin
            new_acc = -12'sd2048;
        end else begin
            new_acc = sum[11:0];
        end
        case (nib[2:0])
            3'd4:    adj = 8'sd2;
            3'd5:    adj = 8'sd5;
            3'd6:    adj = 8'sd7;
            3'd7:    adj = 8'sd9;
            default: adj = -8'sd1;  // small codes step down
        endcase
        idx_sum = $signed({2'b00, base_step}) + adj;
        if (idx_sum < 0) begin
            new_step = '0;
        end else if (idx_sum > step_max) begin
            new_step = 6'(step_max);
        end else begin
            new_step = idx_sum[5:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= nib_valid | nib_restart;   // one item per slot
        end
    end

    always_ff @(posedge clk) begin
        if (nib_valid) begin
            acc_mem[nib_ch]  <= new_acc;
            step_mem[nib_ch] <= new_step;
            dec_pcm          <= {new_acc, 4'b0000};
        end else if (nib_restart) begin     // idle slot
            acc_mem[nib_ch]  <= '0;
            step_mem[nib_ch] <= '0;
            dec_pcm          <= '0;
        end
        dec_ch <= nib_ch;
    end

    a_step_range: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid |-> step_mem[dec_ch] <= 6'(step_max))
        else $error("step index above table end");

endmodule

`default_nettype wire

// File: src/adpcma_level.sv
// total/channel attenuation scaling and left/right pan
`default_nettype none

module adpcma_level (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      dec_valid,
    input  wire adpcma_pkg::ch_idx_t dec_ch,
    input  wire adpcma_pkg::pcm_t    dec_pcm,
    input  wire [1:0]                pan_lr,
    input  wire adpcma_pkg::atten_t  pan_atten,
    output logic                     lvl_valid,
    output adpcma_pkg::ch_idx_t      lvl_ch,
    output adpcma_pkg::pcm_t         lvl_l,
    output adpcma_pkg::pcm_t         lvl_r,
    output adpcma_pkg::ch_idx_t      pan_ch
);
    import adpcma_pkg::*;

    logic [2:0]         coarse, fine;
    logic [3:0]         mult;
    logic signed [19:0] prod, scaled;
    pcm_t               lvl;

    // seq looks up this channel's pan and attenuation
    assign pan_ch = dec_ch;

    assign coarse = pan_atten[5:3];     // whole 6 db steps
    assign fine   = pan_atten[2:0];     // eighths
    assign mult   = 4'd8 - {1'b0, fine};
    assign prod   = dec_pcm * $signed({1'b0, mult});
    assign scaled = (prod >>> 3) >>> coarse;    // arithmetic, sign kept
    assign lvl    = scaled[15:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvl_valid <= 1'b0;
        end else begin
            lvl_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            lvl_ch <= dec_ch;
            lvl_l  <= pan_lr[1] ? lvl : '0;     // bit 7 of pan reg
            lvl_r  <= pan_lr[0] ? lvl : '0;
        end
    end

endmodule

`default_nettype wire

// File: src/adpcma_mix.sv
// frame accumulator, 16-bit saturation and output latch
`default_nettype none

module adpcma_mix #(
    parameter int num_ch = 6
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      lvl_valid,
    input  wire adpcma_pkg::ch_idx_t lvl_ch,
    input  wire adpcma_pkg::pcm_t    lvl_l,
    input  wire adpcma_pkg::pcm_t    lvl_r,
    output adpcma_pkg::pcm_t         pcm_l,
    output adpcma_pkg::pcm_t         pcm_r,
    output logic                     sample_valid
);
    import adpcma_pkg::*;

    localparam int acc_w = 16 + $clog2(num_ch + 1);    // headroom for all channels
    localparam logic signed [acc_w-1:0] pos_lim = 32767;
    localparam logic signed [acc_w-1:0] neg_lim = -32768;

    logic signed [acc_w-1:0] sum_l, sum_r, base_l, base_r, nxt_l, nxt_r;
    logic                    last;

    function automatic pcm_t sat16(input logic signed [acc_w-1:0] v);
        if (v > pos_lim) begin
            return 16'sh7fff;
        end else if (v < neg_lim) begin
            return -16'sh8000;
        end
        return v[15:0];
    endfunction

    always_comb begin
        base_l = sum_l;
        base_r = sum_r;
        if (lvl_ch == '0) begin     // channel 0 opens a new frame
            base_l = '0;
            base_r = '0;
        end
        nxt_l = base_l + lvl_l;
        nxt_r = base_r + lvl_r;
    end

    assign last = lvl_valid && (lvl_ch == ch_idx_t'(num_ch - 1));

    always_ff @(posedge clk) begin
        if (lvl_valid) begin
            sum_l <= nxt_l;
            sum_r <= nxt_r;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_l        <= '0;
            pcm_r        <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= last;
            if (last) begin
                pcm_l <= sat16(nxt_l);
                pcm_r <= sat16(nxt_r);
            end
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid longer than one cycle");

endmodule

`default_nettype wire

// File: src/adpcma_top.sv
// adpcm-a player top: sequencer, decoder, level stage and mixer
`default_nettype none

module adpcma_top #(
    parameter int num_ch = 6
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        wr,
    input  wire adpcma_pkg::reg_addr_t wr_addr,
    input  wire [7:0]                  wr_data,
    output adpcma_pkg::rom_addr_t      rom_addr,
    output logic                       rom_oe_n,
    input  wire [7:0]                  rom_data,
    output logic [num_ch-1:0]          flags,
    output adpcma_pkg::pcm_t           pcm_l,
    output adpcma_pkg::pcm_t           pcm_r,
    output logic                       sample_valid
);
    import adpcma_pkg::*;

    logic       nib_valid, nib_restart, dec_valid, lvl_valid;
    ch_idx_t    nib_ch, dec_ch, lvl_ch, pan_ch;
    nibble_t    nib;
    pcm_t       dec_pcm, lvl_l, lvl_r;
    logic [1:0] pan_lr;
    atten_t     pan_atten;

    adpcma_seq #(.num_ch(num_ch)) u_seq (
        .clk, .rst_n, .wr, .wr_addr, .wr_data, .rom_data, .pan_ch,
        .rom_addr, .rom_oe_n, .flags,
        .nib_valid, .nib_ch, .nib, .nib_restart, .pan_lr, .pan_atten
    );

    adpcma_decode #(.num_ch(num_ch)) u_decode (
        .clk, .rst_n, .nib_valid, .nib_ch, .nib, .nib_restart,
        .dec_valid, .dec_ch, .dec_pcm
    );

    adpcma_level u_level (
        .clk, .rst_n, .dec_valid, .dec_ch, .dec_pcm, .pan_lr, .pan_atten,
        .lvl_valid, .lvl_ch, .lvl_l, .lvl_r, .pan_ch
    );

    adpcma_mix #(.num_ch(num_ch)) u_mix (
        .clk, .rst_n, .lvl_valid, .lvl_ch, .lvl_l, .lvl_r,
        .pcm_l, .pcm_r, .sample_valid
    );

endmodule

`default_nettype wire

// File: dv/adpcma_tb.sv
// adpcm-a player testbench with rom model, register writes, stimulus phases and concurrent checks
`default_nettype none

module adpcma_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import adpcma_pkg::*;

    localparam int num_ch    = 6;
    localparam int frame_len = num_ch * slot_cycles;   // clocks per output sample
    localparam int wait_max  = 20000;                  // cycles allowed for any one wait

    logic              clk, rst_n, wr;
    reg_addr_t         wr_addr;
    logic [7:0]        wr_data, rom_data;
    rom_addr_t         rom_addr, rd_addr;
    logic              rom_oe_n, sample_valid;
    logic [num_ch-1:0] flags;
    pcm_t              pcm_l, pcm_r, prev_l;

    logic [7:0] rom [0:4095];   // blocks 0..15 are enough
    int         phase, phase_q, errors, timeouts, cyc, nreads, last_rd_cyc, dump_cyc;
    logic       oe_q, rd_start, dumped;

    adpcma_top #(.num_ch(num_ch)) dut (
        .clk, .rst_n, .wr, .wr_addr, .wr_data,
        .rom_addr, .rom_oe_n, .rom_data,
        .flags, .pcm_l, .pcm_r, .sample_valid
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_rom();
        logic [31:0] s;
        s = 32'h78be_70ae;
        for (int a = 0; a < 4096; a++) begin
            s = lcg_next(s);
            rom[a] = s[23:16];  // upper lcg bits spread better
        end
        for (int a = 'h100; a < 'h300; a++) begin
            rom[a] = (a < 'h200) ? 8'h00 : 8'h88;   // zero codes in block 1, negative in block 2
        end
    endtask

    // byte shows up one clock after oe goes low
    always @(posedge clk) begin
        if (!rom_oe_n) begin
            rd_addr = rom_addr;
            #1;
            rom_data = rom[rd_addr[11:0]];
        end
    end

    assign rd_start = !rom_oe_n && oe_q;    // first cycle of a read

    // read tracking and previous sample
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cyc         <= 0;
            oe_q        <= 1'b1;
            phase_q     <= 0;
            nreads      <= 0;
            last_rd_cyc <= 0;
            dump_cyc    <= 0;
            dumped      <= 1'b0;
            prev_l      <= '0;
        end else begin
            cyc     <= cyc + 1;
            oe_q    <= rom_oe_n;
            phase_q <= phase;
            if (phase != phase_q) begin     // counts restart with each phase
                nreads <= 0;
                dumped <= 1'b0;
            end else if (rd_start) begin
                nreads      <= nreads + 1;
                last_rd_cyc <= cyc;
            end
            if (wr && wr_addr == reg_key && wr_data[7]) begin
                dumped   <= 1'b1;
                dump_cyc <= cyc;
            end
            if (sample_valid) begin
                prev_l <= pcm_l;
            end
        end
    end

    task automatic note_mismatch(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n) phase == 1 |->
        rom_oe_n && flags == '0 && (!sample_valid || (pcm_l == 0 && pcm_r == 0)))
        else note_mismatch("activity with no channel keyed on");
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n) phase == 2 && rd_start
        |-> rom_addr >= 24'h100 && rom_addr <= 24'h1ff)
        else note_mismatch("read outside block 1");
    a_addr_order: assert property (@(posedge clk) disable iff (!rst_n) phase == 2 && rd_start
        |-> rom_addr == 24'h100 + 24'(nreads))
        else note_mismatch("read address out of sequence");
    a_read_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 2 && rd_start && nreads != 0 |-> cyc - last_rd_cyc == 2 * frame_len)
        else note_mismatch("reads not two frames apart");
    a_end_flag: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 2 && nreads == 256 && cyc == last_rd_cyc + 2 * frame_len |-> flags[0])
        else note_mismatch("end flag of channel 0 not set");
    a_no_reread: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 2 && nreads == 256 |-> !rd_start)
        else note_mismatch("read after end of block");
    // ch0 and ch1 ended before this, only the ch1 flag may survive
    a_flag_clr: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 3 && wr && wr_addr == reg_flag_clr |=> flags == num_ch'(2'b10))
        else note_mismatch("flag clear result wrong");
    a_ramp_up: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 4 && sample_valid && !flags[0] |-> pcm_l >= prev_l && pcm_l >= 0 && pcm_r == 0)
        else note_mismatch("left-only zero codes not a rising ramp");
    a_block2: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 5 && rd_start |-> rom_addr[23:8] == 16'h0002)
        else note_mismatch("read outside block 2");
    a_ramp_down: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 5 && sample_valid && !flags[1] |->
        pcm_l == pcm_r && pcm_l <= 0 && pcm_l <= prev_l)
        else note_mismatch("centre-panned negative codes not a falling ramp");
    a_dump_stop: assert property (@(posedge clk) disable iff (!rst_n)
        phase == 6 && dumped && rd_start |-> cyc - dump_cyc <= frame_len)
        else note_mismatch("read more than a frame after dump");
    a_dump_noflag: assert property (@(posedge clk) disable iff (!rst_n) phase == 6 |-> !flags[0])
        else note_mismatch("dump set the end flag");

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    endtask

    // called 1 ns after an edge and returns 1 ns after the edge that took the write
    task automatic write_reg(input reg_addr_t a, input logic [7:0] d);
        wr      = 1'b1;
        wr_addr = a;
        wr_data = d;
        @(posedge clk);
        #1;
        wr = 1'b0;
    endtask

    task automatic wait_flag(input int b);
        int n;
        n = 0;
        while (!flags[b] && n < wait_max) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!flags[b]) begin
            $display("timeout: end flag of channel %0d never set", b);
            timeouts++;
        end
    endtask

    task automatic wait_samples(input int count);
        int n;
        int got;
        n   = 0;
        got = 0;
        while (got < count && n < wait_max) begin
            @(posedge clk);
            #1;
            n++;
            if (sample_valid) begin
                got++;
            end
        end
        if (got < count) begin
            $display("timeout: only %0d of %0d samples arrived", got, count);
            timeouts++;
        end
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wr       = 1'b0;
        wr_addr  = '0;
        wr_data  = '0;
        rom_data = '0;
        phase    = 0;
        errors   = 0;
        timeouts = 0;
        fill_rom();
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        phase = 1;                  // nothing keyed
        wait_samples(4);
        write_reg(reg_start_lo, 8'h01);
        write_reg(reg_start_hi, 8'h00);
        write_reg(reg_end_lo, 8'h01);
        write_reg(reg_end_hi, 8'h00);
        phase = 2;                  // ch0 through block 1 with pan off
        write_reg(reg_key, 8'h01);
        wait_flag(0);
        wait_samples(3);
        write_reg(reg_pan_base + 6'd1, 8'hc0);  // ch1 on both sides without atten
        write_reg(reg_start_lo + 6'd1, 8'h02);
        write_reg(reg_start_hi + 6'd1, 8'h00);
        write_reg(reg_end_lo + 6'd1, 8'h02);
        write_reg(reg_end_hi + 6'd1, 8'h00);
        phase = 5;
        write_reg(reg_key, 8'h02);
        wait_flag(1);
        wait_samples(2);
        phase = 3;                  // flags now 2'b11
        write_reg(reg_flag_clr, 8'h01);
        wait_samples(2);
        write_reg(reg_pan_base, 8'h80);         // ch0 left only
        phase = 4;
        write_reg(reg_key, 8'h01);
        wait_samples(40);
        phase = 6;                  // dump ch0 mid-block
        write_reg(reg_key, 8'h81);
        wait_samples(4);
        finish_run();
    end

endmodule

`default_nettype wire

// File: filelist.f
src/adpcma_pkg.sv
src/adpcma_seq.sv
src/adpcma_decode.sv
src/adpcma_level.sv
src/adpcma_mix.sv
src/adpcma_top.sv
dv/adpcma_tb.sv

// File: run.sh
#!/bin/sh
# build and run the adpcm-a testbench with verilator, then look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module adpcma_tb \
    -f filelist.f -o adpcma_sim > build.log 2>&1 &&
./obj_dir/adpcma_sim > sim.log 2>&1 ||
{ cat build.log sim.log 2> /dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "^test passed$" sim.log && exit 0 || exit 1
